//--- hdl/ex_pkg.sv
// Execute stage package: widths, operation encodings, issue and register-write structs

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data path width
  localparam int XLEN       = 32;
  // Register file address, 64 entries
  localparam int REG_ADDR_W = 6;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////////////////////////

  // ALU operations, compares and branch conditions share one space
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Low word in one cycle, upper words stepped
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } mult_op_e;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////

  // Everything decode hands to EX for one instruction
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     operand_a;
    word_t     operand_b;
    // Jump target, passed straight to fetch
    word_t     operand_c;
    logic      alu_en;
    mult_op_e  mult_op;
    logic      mult_en;
    logic      csr_access;
    word_t     csr_rdata;
    logic      lsu_en;
    // Forwarding port destination
    reg_addr_t alu_waddr;
    logic      alu_we;
    // Load port destination
    reg_addr_t wb_waddr;
    logic      wb_we;
  } ex_issue_t;

  // One register file write
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } rf_write_t;

endpackage

//--- hdl/ex_alu.sv
// Integer ALU: add/sub, logic, shifts, set-less-than and branch compares
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic                 sub;
  word_t                adder_b;
  logic [XLEN:0]        sum;
  logic                 eq;
  logic                 lt;
  logic                 ltu;
  logic [SHAMT_W-1:0]   shamt;
  logic                 shift_left;
  logic                 shift_arith;
  word_t                shift_in;
  logic signed [XLEN:0] shift_ext;
  logic signed [XLEN:0] shift_full;
  word_t                shift_out;

  ////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////

  // Everything except ADD goes through the subtractor
  assign sub     = (operator_i != ALU_ADD);
  assign adder_b = sub ? ~operand_b_i : operand_b_i;
  assign sum     = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub};

  // Compare flags taken from the difference
  assign eq  = (sum[XLEN-1:0] == '0);
  // Carry out set means a >= b unsigned
  assign ltu = ~sum[XLEN];
  // Signs differ: the negative one is smaller
  assign lt  = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) ? operand_a_i[XLEN-1]
                                                            : sum[XLEN-1];

  ////////////////////////////////////////////////////////////
  // Shared shifter
  ////////////////////////////////////////////////////////////

  // Left shift done as a right shift of the bit-reversed operand
  assign shamt       = operand_b_i[SHAMT_W-1:0];
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shift_in    = shift_left ? {<<{operand_a_i}} : operand_a_i;
  assign shift_ext   = {shift_arith & shift_in[XLEN-1], shift_in};
  assign shift_full  = shift_ext >>> shamt;
  assign shift_out   = shift_left ? {<<{shift_full[XLEN-1:0]}} : shift_full[XLEN-1:0];

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = sum[XLEN-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_out;
      // Set ops also flag the outcome on cmp_o
      ALU_SLT:  cmp_o = lt;
      ALU_SLTU: cmp_o = ltu;
      // Branch conditions
      ALU_EQ:   cmp_o = eq;
      ALU_NE:   cmp_o = ~eq;
      ALU_LT:   cmp_o = lt;
      ALU_GE:   cmp_o = ~lt;
      ALU_LTU:  cmp_o = ltu;
      ALU_GEU:  cmp_o = ~ltu;
      default:  result_o = '0;
    endcase
    // 0/1 result for set and compare ops
    if (operator_i >= ALU_SLT) begin
      result_o = {{(XLEN-1){1'b0}}, cmp_o};
    end
  end

endmodule

//--- hdl/ex_mult.sv
// Multiplier: single-cycle low product and stepped upper product
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; #(
  parameter int MULH_STEPS = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     enable_i,
  input  mult_op_e operator_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  logic     ex_ready_i,
  output word_t    result_o,
  output logic     multicycle_o,
  output logic     ready_o
);

  // Bits of operand b consumed per step
  localparam int SLICE_W = XLEN / MULH_STEPS;
  localparam int STEP_W  = $clog2(MULH_STEPS + 1);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(MULH_STEPS - 1);
  localparam logic [STEP_W-1:0] DONE_STEP = STEP_W'(MULH_STEPS);

  logic [STEP_W-1:0] step_q;
  logic [2*XLEN-1:0] acc_q;
  logic              high_op;
  logic              a_signed;
  logic              b_signed;
  logic              idle;
  logic              busy;
  logic              done;
  logic              advance;
  logic [2*XLEN-1:0] a_ext;
  word_t             b_shifted;
  logic [SLICE_W-1:0] b_slice;
  logic [2*XLEN-1:0] pp;
  logic [2*XLEN-1:0] addend;
  logic [2*XLEN-1:0] acc_base;

  // Low word straight from the full-width product
  assign high_op  = enable_i & (operator_i != MUL_LO);
  assign a_signed = (operator_i == MUL_HSS) | (operator_i == MUL_HSU);
  assign b_signed = (operator_i == MUL_HSS);

  ////////////////////////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////////////////////////

  // step_q 0 is idle, DONE_STEP holds the final result
  assign idle    = (step_q == '0);
  assign done    = (step_q == DONE_STEP);
  assign busy    = ~idle & ~done;
  assign advance = (idle & high_op) | busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q <= '0;
    end else if (advance) begin
      step_q <= step_q + 1'b1;
    end else if (done && ex_ready_i) begin
      // Stage accepted the result
      step_q <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Partial products
  ////////////////////////////////////////////////////////////

  assign a_ext     = {{XLEN{a_signed & op_a_i[XLEN-1]}}, op_a_i};
  assign b_shifted = op_b_i >> (step_q * SLICE_W);
  assign b_slice   = b_shifted[SLICE_W-1:0];
  assign pp        = (a_ext * {{(2*XLEN-SLICE_W){1'b0}}, b_slice}) << (step_q * SLICE_W);

  // Negative signed b weighs its top bit -2^XLEN, fixed up on the last slice
  assign addend = (step_q == LAST_STEP && b_signed && op_b_i[XLEN-1])
                ? pp - (a_ext << XLEN)
                : pp;

  // First step starts from zero
  assign acc_base = idle ? '0 : acc_q;

  always_ff @(posedge clk) begin
    if (advance) begin
      acc_q <= acc_base + addend;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign result_o     = done ? acc_q[2*XLEN-1:XLEN] : op_a_i * op_b_i;
  assign multicycle_o = done;
  // Stalls from issue until the last slice is accumulated
  assign ready_o      = done | (idle & ~high_op);

endmodule

//--- hdl/ex_wb_port.sv
// EX/WB pipeline register and load write-port mux
`timescale 1ns/1ps

module ex_wb_port import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid_i,
  input  logic      wb_ready_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_waddr_i,
  input  word_t     lsu_rdata_i,
  output rf_write_t wb_o
);

  logic      we_q;
  reg_addr_t waddr_q;

  // Write enable follows each valid instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= wb_we_i;
    end else if (wb_ready_i) begin
      // WB free and nothing valid here, flush the pending write
      we_q <= 1'b0;
    end
  end

  // Destination only moves when a load write is coming
  always_ff @(posedge clk) begin
    if (ex_valid_i && wb_we_i) begin
      waddr_q <= wb_waddr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Load write port
  ////////////////////////////////////////////////////////////

  always_comb begin
    // wb_ready_i doubles as the LSU data valid
    wb_o.we    = we_q & wb_ready_i;
    wb_o.waddr = waddr_q;
    wb_o.wdata = lsu_rdata_i;
  end

endmodule

//--- hdl/ex_ctrl.sv
// Stall and valid control with the forwarding write-port mux
`timescale 1ns/1ps

module ex_ctrl import ex_pkg::*; (
  input  ex_issue_t issue_i,
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  output rf_write_t fw_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic units_ready;
  logic unit_active;

  ////////////////////////////////////////////////////////////
  // Forwarding write port
  ////////////////////////////////////////////////////////////

  // CSR read beats multiplier beats ALU
  always_comb begin
    fw_o.we    = issue_i.alu_we;
    fw_o.waddr = issue_i.alu_waddr;
    fw_o.wdata = '0;
    if (issue_i.csr_access) begin
      fw_o.wdata = issue_i.csr_rdata;
    end else if (issue_i.mult_en) begin
      fw_o.wdata = mult_result_i;
    end else if (issue_i.alu_en) begin
      fw_o.wdata = alu_result_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Multiplier, LSU and WB all able to take the instruction
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Some unit is doing work this cycle
  assign unit_active = issue_i.alu_en | issue_i.mult_en | issue_i.csr_access
                     | issue_i.lsu_en;

  // Branches resolve here and never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid flows downstream only, so no loop through ex_ready
  assign ex_valid_o = unit_active & units_ready;

endmodule

//--- hdl/ex_stage.sv
// Execute stage top: ALU, multiplier, control and EX/WB port
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int MULH_STEPS = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  // From decode
  input  ex_issue_t issue_i,
  input  logic      branch_in_ex_i,
  // From the LSU
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  // From writeback
  input  logic      wb_ready_i,
  // Register file ports
  output rf_write_t fw_o,
  output rf_write_t wb_o,
  // To fetch
  output word_t     jump_target_o,
  output logic      branch_decision_o,
  output logic      mult_multicycle_o,
  // Handshake
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  word_t mult_result;
  logic  mult_ready;

  // Target was computed in decode
  assign jump_target_o = issue_i.operand_c;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  ex_ctrl u_ctrl (
    .issue_i        (issue_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .fw_o           (fw_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Compare outcome is the branch decision
  ex_alu u_alu (
    .operator_i  (issue_i.alu_op),
    .operand_a_i (issue_i.operand_a),
    .operand_b_i (issue_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (branch_decision_o)
  );

  ex_mult #(
    .MULH_STEPS (MULH_STEPS)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (issue_i.mult_en),
    .operator_i   (issue_i.mult_op),
    .op_a_i       (issue_i.operand_a),
    .op_b_i       (issue_i.operand_b),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  // Load results bypass EX and land one cycle later
  ex_wb_port u_wb_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid_i  (ex_valid_o),
    .wb_ready_i  (wb_ready_i),
    .wb_we_i     (issue_i.wb_we),
    .wb_waddr_i  (issue_i.wb_waddr),
    .lsu_rdata_i (lsu_rdata_i),
    .wb_o        (wb_o)
  );

endmodule

//--- tb/ex_stage_assert.sv
// Handshake assertions bound to the execute stage top
`timescale 1ns/1ps

module ex_stage_assert import ex_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input ex_issue_t issue_i,
  input logic      wb_ready_i,
  input rf_write_t wb_o,
  input logic      ex_valid_o,
  input logic      mult_multicycle_o
);

  // Read back by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Nothing leaves EX while writeback is stalled
  a_valid_wb: assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o |-> wb_ready_i)
    else begin
      fail_count = fail_count + 1;
      $error("ex_valid_o high while wb_ready_i low");
    end

  // Load port only writes when WB takes it
  a_we_wb: assert property (@(posedge clk) disable iff (!rst_n) wb_o.we |-> wb_ready_i)
    else begin
      fail_count = fail_count + 1;
      $error("wb_o.we high while wb_ready_i low");
    end

  // Final multiply cycle belongs to a multiply issue
  a_mul_en: assert property (@(posedge clk) disable iff (!rst_n)
                             mult_multicycle_o |-> issue_i.mult_en)
    else begin
      fail_count = fail_count + 1;
      $error("mult_multicycle_o high without mult_en");
    end

endmodule

//--- tb/ex_stage_tb.sv
// Execute stage testbench with clock, reset, stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  localparam int MULH_STEPS   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int N_ALU        = 48;
  localparam int N_BR         = 24;
  localparam int N_MUL        = 24;
  localparam int N_LD         = 8;
  // Priority and back-pressure add a handful more
  localparam int NUM_TXN      = N_ALU + N_BR + N_MUL + 2 * N_LD + 8;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 20 * NUM_TXN) * 100;

  logic      clk;
  logic      rst_n;
  ex_issue_t issue;
  logic      branch_in_ex;
  word_t     lsu_rdata;
  logic      lsu_ready_ex;
  logic      wb_ready;
  rf_write_t fw;
  rf_write_t wb;
  word_t     jump_target;
  logic      branch_decision;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;
  logic [31:0] rng_state;
  rf_write_t exp_fw;
  logic      exp_cmp;

  ex_stage #(.MULH_STEPS(MULH_STEPS)) dut (
    .clk(clk), .rst_n(rst_n), .issue_i(issue), .branch_in_ex_i(branch_in_ex),
    .lsu_rdata_i(lsu_rdata), .lsu_ready_ex_i(lsu_ready_ex), .wb_ready_i(wb_ready),
    .fw_o(fw), .wb_o(wb), .jump_target_o(jump_target), .branch_decision_o(branch_decision),
    .mult_multicycle_o(mult_multicycle), .ex_ready_o(ex_ready), .ex_valid_o(ex_valid)
  );

  bind ex_stage ex_stage_assert u_assert (
    .clk(clk), .rst_n(rst_n), .issue_i(issue_i), .wb_ready_i(wb_ready_i), .wb_o(wb_o),
    .ex_valid_o(ex_valid_o), .mult_multicycle_o(mult_multicycle_o)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic is_high_mul(input ex_issue_t iss);
    return iss.mult_en && (iss.mult_op != MUL_LO);
  endfunction

  // Expected forwarding write with the branch outcome through cmp
  function automatic rf_write_t ref_fw(input ex_issue_t iss, output logic cmp);
    rf_write_t   w;
    word_t       a;
    word_t       b;
    word_t       alu;
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    a = iss.operand_a;
    b = iss.operand_b;
    case (iss.alu_op)
      ALU_SLT, ALU_LT:   cmp = $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: cmp = a < b;
      ALU_GE:            cmp = $signed(a) >= $signed(b);
      ALU_GEU:           cmp = a >= b;
      ALU_EQ:            cmp = a == b;
      ALU_NE:            cmp = a != b;
      default:           cmp = 1'b0;
    endcase
    case (iss.alu_op)
      ALU_ADD: alu = a + b;
      ALU_SUB: alu = a - b;
      ALU_AND: alu = a & b;
      ALU_OR:  alu = a | b;
      ALU_XOR: alu = a ^ b;
      ALU_SLL: alu = a << b[4:0];
      ALU_SRL: alu = a >> b[4:0];
      ALU_SRA: alu = $signed(a) >>> b[4:0];
      default: alu = {31'b0, cmp};
    endcase
    // Extend by operator, then take the wanted half of the 64-bit product
    a64  = (iss.mult_op inside {MUL_HSS, MUL_HSU}) ? {{32{a[31]}}, a} : {32'b0, a};
    b64  = (iss.mult_op == MUL_HSS) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = a64 * b64;
    w.we    = iss.alu_we;
    w.waddr = iss.alu_waddr;
    if (iss.csr_access) w.wdata = iss.csr_rdata;
    else if (iss.mult_en) w.wdata = (iss.mult_op == MUL_LO) ? prod[31:0] : prod[63:32];
    else if (iss.alu_en) w.wdata = alu;
    else w.wdata = '0;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_write(input rf_write_t got, input rf_write_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "%s got we=%b waddr=%0d wdata=%h, expected we=%b waddr=%0d wdata=%h",
        what, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata));
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s got %b, expected %b", what, got, exp));
  endtask

  // Forwarding port and branch flag against the model at mid-cycle
  // High multiplies only count once the stage accepts them
  always @(negedge clk) begin
    if (rst_n && !(is_high_mul(issue) && !ex_ready)) begin
      exp_fw = ref_fw(issue, exp_cmp);
      check_write(fw, exp_fw, "fw_o");
      check_bit(branch_decision, exp_cmp, "branch_decision_o");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic ex_issue_t rand_alu_issue();
    ex_issue_t   iss;
    logic [31:0] r;
    iss = '0;
    r = xorshift32();
    iss.alu_op    = alu_op_e'(r[3:0]);
    iss.operand_a = xorshift32();
    // Equal operands now and then for EQ/NE/GE
    iss.operand_b = (r[5:4] == 2'b00) ? iss.operand_a : xorshift32();
    iss.alu_en    = 1'b1;
    iss.alu_we    = 1'b1;
    iss.alu_waddr = r[13:8];
    return iss;
  endfunction

  task automatic alu_ops();
    for (int i = 0; i < N_ALU; i++) begin
      next_cycle();
      issue = rand_alu_issue();
      @(negedge clk);
      check_bit(ex_ready, 1'b1, "ex_ready_o on ALU op");
      check_bit(ex_valid, 1'b1, "ex_valid_o on ALU op");
    end
  endtask

  task automatic branch_ops();
    ex_issue_t   iss;
    logic [31:0] r;
    logic        cmp;
    for (int i = 0; i < N_BR; i++) begin
      iss = rand_alu_issue();
      r = xorshift32();
      iss.alu_op    = alu_op_e'({1'b1, r[2:0]});
      iss.alu_we    = 1'b0;
      iss.operand_c = xorshift32();
      void'(ref_fw(iss, cmp));
      next_cycle();
      issue        = iss;
      branch_in_ex = 1'b1;
      wb_ready     = r[3];
      @(negedge clk);
      check_bit(branch_decision, cmp, "branch decision");
      check_word(jump_target, iss.operand_c, "jump_target_o");
      check_bit(ex_ready, 1'b1, "ex_ready_o on branch");
    end
    next_cycle();
    issue        = '0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b1;
  endtask

  task automatic mult_ops();
    ex_issue_t   iss;
    rf_write_t   exp;
    logic [31:0] r;
    logic        cmp;
    int          waits;
    for (int i = 0; i < N_MUL; i++) begin
      r = xorshift32();
      iss = '0;
      iss.mult_en   = 1'b1;
      iss.mult_op   = mult_op_e'(r[1:0]);
      iss.operand_a = xorshift32();
      iss.operand_b = xorshift32();
      iss.alu_we    = 1'b1;
      iss.alu_waddr = reg_addr_t'(r[13:8]);
      exp = ref_fw(iss, cmp);
      next_cycle();
      issue = iss;
      waits = 0;
      @(negedge clk);
      while (!ex_ready) begin
        check_bit(ex_valid, 1'b0, "ex_valid_o while multiplier busy");
        waits++;
        @(negedge clk);
      end
      check_bit(mult_multicycle, is_high_mul(iss), "mult_multicycle_o");
      check_word(fw.wdata, exp.wdata, "multiplier result");
      check_bit(waits == (is_high_mul(iss) ? MULH_STEPS : 0), 1'b1, "multiplier stall length");
    end
  endtask

  task automatic write_priority();
    ex_issue_t iss;
    rf_write_t exp;
    logic      cmp;
    iss = rand_alu_issue();
    iss.mult_en    = 1'b1;
    iss.mult_op    = MUL_LO;
    iss.csr_access = 1'b1;
    iss.csr_rdata  = xorshift32();
    next_cycle();
    issue = iss;
    @(negedge clk);
    check_word(fw.wdata, iss.csr_rdata, "CSR over multiplier and ALU");
    iss.csr_access = 1'b0;
    exp = ref_fw(iss, cmp);
    next_cycle();
    issue = iss;
    @(negedge clk);
    check_word(fw.wdata, exp.wdata, "multiplier over ALU");
  endtask

  task automatic load_writes();
    ex_issue_t iss;
    rf_write_t exp;
    for (int i = 0; i < N_LD; i++) begin
      iss = '0;
      iss.lsu_en   = 1'b1;
      iss.wb_we    = 1'b1;
      iss.wb_waddr = reg_addr_t'(xorshift32());
      next_cycle();
      issue = iss;
      @(negedge clk);
      check_bit(ex_valid, 1'b1, "ex_valid_o on load");
      next_cycle();
      issue     = '0;
      lsu_rdata = xorshift32();
      // Odd rounds stall writeback for one cycle first
      wb_ready  = (i % 2 == 0);
      @(negedge clk);
      if (i % 2 != 0) begin
        check_bit(wb.we, 1'b0, "wb_o.we while writeback stalled");
        next_cycle();
        wb_ready = 1'b1;
        @(negedge clk);
      end
      exp.we    = 1'b1;
      exp.waddr = iss.wb_waddr;
      exp.wdata = lsu_rdata;
      check_write(wb, exp, "wb_o after load");
      next_cycle();
      @(negedge clk);
      check_bit(wb.we, 1'b0, "wb_o.we after idle cycle");
    end
  endtask

  task automatic back_pressure();
    for (int k = 0; k < 2; k++) begin
      next_cycle();
      issue        = rand_alu_issue();
      lsu_ready_ex = (k != 0);
      wb_ready     = (k == 0);
      @(negedge clk);
      check_bit(ex_ready, 1'b0, "ex_ready_o under back-pressure");
      check_bit(ex_valid, 1'b0, "ex_valid_o under back-pressure");
      next_cycle();
      lsu_ready_ex = 1'b1;
      wb_ready     = 1'b1;
      @(negedge clk);
      check_bit(ex_ready, 1'b1, "ex_ready_o after release");
      check_bit(ex_valid, 1'b1, "ex_valid_o after release");
    end
  endtask

  initial begin
    rng_state    = 32'd80940;
    rst_n        = 1'b0;
    issue        = '0;
    branch_in_ex = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Pending load write and step counter start cleared
    @(negedge clk);
    check_bit(wb.we, 1'b0, "wb_o.we after reset");
    check_bit(mult_multicycle, 1'b0, "mult_multicycle_o after reset");
    alu_ops();
    branch_ops();
    mult_ops();
    write_priority();
    load_writes();
    back_pressure();
    next_cycle();
    issue = '0;
    @(negedge clk);
    if (dut.u_assert.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("%0d handshake assertion failures", dut.u_assert.fail_count);
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sources.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_port.sv
hdl/ex_ctrl.sv
hdl/ex_stage.sv
tb/ex_stage_assert.sv
tb/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb \
    -f sources.f -Mdir "$BUILD_DIR"; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/Vex_stage_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
fi
echo "Result: FAIL"
exit 1
